// ==== src/dbg_pkg.sv ====
`default_nettype none

package dbg_pkg;

    localparam int WORD_W          = 32;
    localparam int NUM_REGS        = 32;
    localparam int NUM_LATCH_WORDS = 11;

    // pipeline latch widths
    localparam int IF_ID_W  = 64;
    localparam int ID_EX_W  = 139;
    localparam int EX_MEM_W = 76;
    localparam int MEM_WB_W = 71;

    localparam int DMEM_ADDR_W = 8; // byte address, 64 words scanned
    localparam logic [DMEM_ADDR_W-1:0] DMEM_LAST_ADDR = DMEM_ADDR_W'((2 ** DMEM_ADDR_W) - 4);

    localparam int DRAIN_CYCLES    = 3; // end instr in decode until the last real one retires
    localparam int FIFO_DEPTH_LOG2 = 4;

    typedef enum logic [3:0] {
        GRAL_IDLE          = 4'd0,
        LO_IDLE            = 4'd1,
        LO_ASSIGN          = 4'd2,
        LO_INSTR_LOADED    = 4'd3,
        CNT_EXEC           = 4'd4,
        SEND_REGISTERS     = 4'd5,
        SEND_LATCHES       = 4'd6,
        SEND_MEM_DATA      = 4'd7,
        SEND_MEM_DATA_ADDR = 4'd8,
        SEND_END_DATA      = 4'd9,
        ST_IDLE            = 4'd10,
        ST_ASSIGN          = 4'd11,
        ST_STAGE_EXECUTED  = 4'd12
    } debug_state_e;

    // host commands, ascii packed msb first
    typedef enum logic [WORD_W-1:0] {
        CMD_LOAD   = 32'h006c_6f6d, // "\0lom"
        CMD_CONT   = 32'h0063_6f6d, // "\0com"
        CMD_STEP   = 32'h0073_746d, // "\0stm"
        CMD_NEXT   = 32'h6e78_7374, // "nxst"
        CMD_CANCEL = 32'h636c_7374  // "clst"
    } host_cmd_e;

    localparam logic [WORD_W-1:0] END_INSTR = 32'hffff_ffff;
    localparam logic [WORD_W-1:0] END_DATA  = 32'h656e_6464; // "endd"

endpackage

`default_nettype wire

// ==== src/rx_word_assembler.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_word_assembler (
    input  wire                      i_clk,
    input  wire                      i_reset,
    input  wire                      i_byte_valid,
    input  wire  [7:0]               i_byte,
    output logic                     o_word_ready,
    output logic [dbg_pkg::WORD_W-1:0] o_word
);

    logic [23:0] shift; // first three bytes of the word
    logic [1:0]  byte_cnt;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            byte_cnt     <= 2'd0;
            o_word_ready <= 1'b0;
        end else begin
            o_word_ready <= 1'b0;
            if (i_byte_valid) begin
                byte_cnt <= byte_cnt + 2'd1; // wraps after the fourth byte
                if (byte_cnt == 2'd3) begin
                    o_word_ready <= 1'b1;
                end
            end
        end
    end

    // payload path
    always_ff @(posedge i_clk) begin
        if (i_byte_valid) begin
            shift <= {shift[15:0], i_byte};
            if (byte_cnt == 2'd3) begin
                o_word <= {shift, i_byte}; // first byte lands in the msb
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/debug_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module debug_unit (
    input  wire                            i_clk,
    input  wire                            i_reset,
    input  wire                            i_data_ready,
    input  wire  [dbg_pkg::WORD_W-1:0]     i_data,
    input  wire                            i_program_end,
    input  wire  [dbg_pkg::IF_ID_W-1:0]    i_if_id_latch,
    input  wire  [dbg_pkg::ID_EX_W-1:0]    i_id_ex_latch,
    input  wire  [dbg_pkg::EX_MEM_W-1:0]   i_ex_mem_latch,
    input  wire  [dbg_pkg::MEM_WB_W-1:0]   i_mem_wb_latch,
    input  wire  [dbg_pkg::WORD_W-1:0]     i_register_content,
    input  wire  [dbg_pkg::WORD_W-1:0]     i_mem_data_content,
    input  wire                            i_fifo_full,
    output logic                           o_halt,
    output logic                           o_pc_reset,
    output logic                           o_stall,
    output logic                           o_write_instruction_flag,
    output logic [dbg_pkg::WORD_W-1:0]     o_instruction_to_write,
    output logic [dbg_pkg::WORD_W-1:0]     o_address_to_write_inst,
    output logic [4:0]                     o_reg_addr_to_read,
    output logic [dbg_pkg::DMEM_ADDR_W-1:0] o_addr_to_read_mem_data,
    output logic [dbg_pkg::WORD_W-1:0]     o_data_to_fifo,
    output logic                           o_write_en_fifo
);

    dbg_pkg::debug_state_e state;

    logic        prog_ready;
    logic        step_mode;
    logic        last_instr;  // END_INSTR is the word being written
    logic [1:0]  drain_cnt;
    logic [3:0]  latch_idx;
    logic [31:0] latch_word;
    logic        can_push;
    logic        mem_last;

    // a push is never issued right after another, so full is always seen in time
    assign can_push = !i_fifo_full && !o_write_en_fifo;
    assign mem_last = (o_addr_to_read_mem_data == dbg_pkg::DMEM_LAST_ADDR);

    always_comb begin
        case (latch_idx)
            4'd0:    latch_word = i_if_id_latch[31:0];
            4'd1:    latch_word = i_if_id_latch[63:32];
            4'd2:    latch_word = i_id_ex_latch[31:0];
            4'd3:    latch_word = i_id_ex_latch[63:32];
            4'd4:    latch_word = i_id_ex_latch[95:64];
            4'd5:    latch_word = i_id_ex_latch[127:96];
            4'd6:    latch_word = {i_ex_mem_latch[20:0], i_id_ex_latch[138:128]};
            4'd7:    latch_word = i_ex_mem_latch[52:21];
            4'd8:    latch_word = {i_mem_wb_latch[8:0], i_ex_mem_latch[75:53]};
            4'd9:    latch_word = i_mem_wb_latch[40:9];
            default: latch_word = {2'b00, i_mem_wb_latch[70:41]}; // top two bits unused
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state                    <= dbg_pkg::GRAL_IDLE;
            o_halt                   <= 1'b1;
            o_pc_reset               <= 1'b0;
            o_stall                  <= 1'b0;
            o_write_instruction_flag <= 1'b0;
            o_write_en_fifo          <= 1'b0;
            o_address_to_write_inst  <= '0;
            o_reg_addr_to_read       <= '0;
            o_addr_to_read_mem_data  <= '0;
            prog_ready               <= 1'b0;
            step_mode                <= 1'b0;
            last_instr               <= 1'b0;
            drain_cnt                <= 2'd0;
            latch_idx                <= 4'd0;
        end else begin
            o_pc_reset               <= 1'b0; // pulses by default
            o_write_instruction_flag <= 1'b0;
            o_write_en_fifo          <= 1'b0;

            case (state)
                dbg_pkg::GRAL_IDLE: begin
                    step_mode <= 1'b0;
                    if (i_data_ready) begin
                        if (i_data == dbg_pkg::CMD_LOAD) begin
                            prog_ready              <= 1'b0;
                            o_address_to_write_inst <= '0;
                            state                   <= dbg_pkg::LO_IDLE;
                        end else if (i_data == dbg_pkg::CMD_CONT && prog_ready) begin
                            o_halt    <= 1'b0; // release the pipeline
                            drain_cnt <= 2'd0;
                            state     <= dbg_pkg::CNT_EXEC;
                        end else if (i_data == dbg_pkg::CMD_STEP && prog_ready) begin
                            step_mode <= 1'b1;
                            state     <= dbg_pkg::ST_IDLE;
                        end
                    end
                end

                dbg_pkg::LO_IDLE: begin
                    if (i_data_ready) begin
                        o_write_instruction_flag <= 1'b1;
                        o_instruction_to_write   <= i_data;
                        last_instr               <= (i_data == dbg_pkg::END_INSTR);
                        state                    <= dbg_pkg::LO_ASSIGN;
                    end
                end

                dbg_pkg::LO_ASSIGN: state <= dbg_pkg::LO_INSTR_LOADED; // write strobe is out

                dbg_pkg::LO_INSTR_LOADED: begin
                    if (last_instr) begin
                        o_address_to_write_inst <= '0;
                        o_pc_reset              <= 1'b1;
                        prog_ready              <= 1'b1;
                        state                   <= dbg_pkg::GRAL_IDLE;
                    end else begin
                        o_address_to_write_inst <= o_address_to_write_inst + 32'd4;
                        state                   <= dbg_pkg::LO_IDLE;
                    end
                end

                dbg_pkg::CNT_EXEC: begin
                    if (i_program_end) begin
                        if (drain_cnt == 2'(dbg_pkg::DRAIN_CYCLES)) begin
                            o_halt             <= 1'b1; // pipeline fully drained
                            o_stall            <= 1'b0;
                            o_reg_addr_to_read <= '0;
                            state              <= dbg_pkg::SEND_REGISTERS;
                        end else begin
                            o_stall   <= 1'b1; // keep fetch parked on the end instr
                            drain_cnt <= drain_cnt + 2'd1;
                        end
                    end
                end

                dbg_pkg::ST_IDLE: begin
                    if (i_data_ready) begin
                        if (i_data == dbg_pkg::CMD_NEXT) begin
                            o_halt <= 1'b0;
                            state  <= dbg_pkg::ST_ASSIGN;
                        end else if (i_data == dbg_pkg::CMD_CANCEL) begin
                            o_pc_reset <= 1'b1;
                            state      <= dbg_pkg::GRAL_IDLE;
                        end
                    end
                end

                dbg_pkg::ST_ASSIGN: begin
                    o_halt <= 1'b1; // one stage has advanced
                    state  <= dbg_pkg::ST_STAGE_EXECUTED;
                end

                dbg_pkg::ST_STAGE_EXECUTED: begin
                    o_reg_addr_to_read <= '0;
                    state              <= dbg_pkg::SEND_REGISTERS;
                end

                dbg_pkg::SEND_REGISTERS: begin
                    if (can_push) begin
                        o_write_en_fifo    <= 1'b1;
                        o_data_to_fifo     <= i_register_content;
                        o_reg_addr_to_read <= o_reg_addr_to_read + 5'd1;
                        if (o_reg_addr_to_read == 5'(dbg_pkg::NUM_REGS - 1)) begin
                            latch_idx <= 4'd0;
                            state     <= dbg_pkg::SEND_LATCHES;
                        end
                    end
                end

                dbg_pkg::SEND_LATCHES: begin
                    if (can_push) begin
                        o_write_en_fifo <= 1'b1;
                        o_data_to_fifo  <= latch_word;
                        latch_idx       <= latch_idx + 4'd1;
                        if (latch_idx == 4'(dbg_pkg::NUM_LATCH_WORDS - 1)) begin
                            o_addr_to_read_mem_data <= '0;
                            state                   <= dbg_pkg::SEND_MEM_DATA;
                        end
                    end
                end

                dbg_pkg::SEND_MEM_DATA: begin
                    if (i_mem_data_content != '0) begin
                        if (can_push) begin
                            o_write_en_fifo <= 1'b1;
                            o_data_to_fifo  <= i_mem_data_content;
                            state           <= dbg_pkg::SEND_MEM_DATA_ADDR;
                        end
                    end else if (mem_last) begin
                        state <= dbg_pkg::SEND_END_DATA;
                    end else begin
                        o_addr_to_read_mem_data <= o_addr_to_read_mem_data + 'd4; // skip zero word
                    end
                end

                dbg_pkg::SEND_MEM_DATA_ADDR: begin
                    if (can_push) begin
                        o_write_en_fifo <= 1'b1;
                        o_data_to_fifo  <= 32'(o_addr_to_read_mem_data);
                        if (mem_last) begin
                            state <= dbg_pkg::SEND_END_DATA;
                        end else begin
                            o_addr_to_read_mem_data <= o_addr_to_read_mem_data + 'd4;
                            state                   <= dbg_pkg::SEND_MEM_DATA;
                        end
                    end
                end

                dbg_pkg::SEND_END_DATA: begin
                    if (can_push) begin
                        o_write_en_fifo <= 1'b1;
                        o_data_to_fifo  <= dbg_pkg::END_DATA;
                        if (step_mode) begin
                            state <= dbg_pkg::ST_IDLE;
                        end else begin
                            o_pc_reset <= 1'b1; // continuous run is over
                            state      <= dbg_pkg::GRAL_IDLE;
                        end
                    end
                end

                default: state <= dbg_pkg::GRAL_IDLE;
            endcase
        end
    end

    // the fifo's full flag must never be outrun by a registered push
    a_push_not_full: assert property (@(posedge i_clk) disable iff (i_reset)
        o_write_en_fifo |-> !i_fifo_full);

    a_idle_halted: assert property (@(posedge i_clk) disable iff (i_reset)
        (state == dbg_pkg::GRAL_IDLE) |-> o_halt);

endmodule

`default_nettype wire

// ==== src/tx_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_fifo (
    input  wire                        i_clk,
    input  wire                        i_reset,
    input  wire                        i_push,
    input  wire  [dbg_pkg::WORD_W-1:0] i_wdata,
    input  wire                        i_pop,
    output logic [dbg_pkg::WORD_W-1:0] o_rdata,
    output logic                       o_full,
    output logic                       o_empty
);

    localparam int AW = dbg_pkg::FIFO_DEPTH_LOG2;

    logic [dbg_pkg::WORD_W-1:0] mem [2**AW];
    logic [AW-1:0]              wr_ptr;
    logic [AW-1:0]              rd_ptr;
    logic [AW:0]                count;

    assign o_rdata = mem[rd_ptr]; // head word shows before the pop
    assign o_full  = (count == (AW+1)'(2 ** AW));
    assign o_empty = (count == '0);

    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_wdata;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({i_push, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge i_clk) disable iff (i_reset) i_push |-> !o_full);
    a_no_underflow: assert property (@(posedge i_clk) disable iff (i_reset) i_pop |-> !o_empty);

endmodule

`default_nettype wire

// ==== src/tx_byte_sender.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_byte_sender (
    input  wire                        i_clk,
    input  wire                        i_reset,
    input  wire                        i_fifo_empty,
    input  wire  [dbg_pkg::WORD_W-1:0] i_fifo_rdata,
    output logic                       o_fifo_pop,
    input  wire                        i_tx_busy,
    output logic                       o_tx_start,
    output logic [7:0]                 o_tx_byte
);

    logic [dbg_pkg::WORD_W-1:0] word; // shifts left as bytes leave
    logic                       have_word;
    logic [1:0]                 byte_idx;
    logic                       busy_low_q;
    logic                       send;

    assign o_fifo_pop = !have_word && !i_fifo_empty;
    // busy low now and last cycle, and no start still in flight
    assign send = have_word && !i_tx_busy && busy_low_q && !o_tx_start;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            have_word  <= 1'b0;
            byte_idx   <= 2'd0;
            busy_low_q <= 1'b0;
            o_tx_start <= 1'b0;
        end else begin
            busy_low_q <= !i_tx_busy;
            o_tx_start <= send;
            if (o_fifo_pop) begin
                have_word <= 1'b1;
                byte_idx  <= 2'd0;
            end else if (send) begin
                byte_idx <= byte_idx + 2'd1;
                if (byte_idx == 2'd3) begin
                    have_word <= 1'b0; // last byte handed off
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_fifo_pop) begin
            word <= i_fifo_rdata;
        end else if (send) begin
            word      <= {word[23:0], 8'h00};
            o_tx_byte <= word[31:24]; // msb first
        end
    end

endmodule

`default_nettype wire

// ==== src/debug_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module debug_subsystem (
    input  wire                             i_clk,
    input  wire                             i_reset,
    input  wire                             i_rx_byte_valid,
    input  wire  [7:0]                      i_rx_byte,
    input  wire                             i_tx_busy,
    output logic                            o_tx_start,
    output logic [7:0]                      o_tx_byte,
    output logic                            o_halt,
    output logic                            o_pc_reset,
    output logic                            o_stall,
    output logic                            o_imem_we,
    output logic [dbg_pkg::WORD_W-1:0]      o_imem_addr,
    output logic [dbg_pkg::WORD_W-1:0]      o_imem_data,
    output logic [4:0]                      o_reg_addr,
    output logic [dbg_pkg::DMEM_ADDR_W-1:0] o_dmem_addr,
    input  wire  [dbg_pkg::WORD_W-1:0]      i_reg_data,
    input  wire  [dbg_pkg::WORD_W-1:0]      i_dmem_data,
    input  wire                             i_program_end,
    input  wire  [dbg_pkg::IF_ID_W-1:0]     i_if_id,
    input  wire  [dbg_pkg::ID_EX_W-1:0]     i_id_ex,
    input  wire  [dbg_pkg::EX_MEM_W-1:0]    i_ex_mem,
    input  wire  [dbg_pkg::MEM_WB_W-1:0]    i_mem_wb
);

    logic                       word_ready;
    logic [dbg_pkg::WORD_W-1:0] word_data;
    logic                       fifo_push;
    logic [dbg_pkg::WORD_W-1:0] fifo_wdata;
    logic                       fifo_pop;
    logic [dbg_pkg::WORD_W-1:0] fifo_rdata;
    logic                       fifo_full;
    logic                       fifo_empty;

    rx_word_assembler i_rx_word_assembler (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_byte_valid(i_rx_byte_valid), .i_byte(i_rx_byte),
        .o_word_ready(word_ready), .o_word(word_data)
    );

    debug_unit i_debug_unit (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_data_ready(word_ready), .i_data(word_data),
        .i_program_end(i_program_end),
        .i_if_id_latch(i_if_id), .i_id_ex_latch(i_id_ex),
        .i_ex_mem_latch(i_ex_mem), .i_mem_wb_latch(i_mem_wb),
        .i_register_content(i_reg_data), .i_mem_data_content(i_dmem_data),
        .i_fifo_full(fifo_full),
        .o_halt(o_halt), .o_pc_reset(o_pc_reset), .o_stall(o_stall),
        .o_write_instruction_flag(o_imem_we),
        .o_instruction_to_write(o_imem_data),
        .o_address_to_write_inst(o_imem_addr),
        .o_reg_addr_to_read(o_reg_addr), .o_addr_to_read_mem_data(o_dmem_addr),
        .o_data_to_fifo(fifo_wdata), .o_write_en_fifo(fifo_push)
    );

    tx_fifo i_tx_fifo (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_push(fifo_push), .i_wdata(fifo_wdata),
        .i_pop(fifo_pop), .o_rdata(fifo_rdata),
        .o_full(fifo_full), .o_empty(fifo_empty)
    );

    tx_byte_sender i_tx_byte_sender (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_fifo_empty(fifo_empty), .i_fifo_rdata(fifo_rdata), .o_fifo_pop(fifo_pop),
        .i_tx_busy(i_tx_busy), .o_tx_start(o_tx_start), .o_tx_byte(o_tx_byte)
    );

endmodule

`default_nettype wire

// ==== testbench/debug_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module debug_checker (
    input wire                            i_clk,
    input wire                            i_reset,
    input wire                            i_tx_start,
    input wire [7:0]                      i_tx_byte,
    input wire                            i_imem_we,
    input wire [dbg_pkg::WORD_W-1:0]      i_imem_addr,
    input wire [dbg_pkg::WORD_W-1:0]      i_imem_data,
    input wire                            i_halt,
    input wire                            i_pc_reset,
    input wire                            i_stall,
    input wire                            i_fifo_full,
    input wire [dbg_pkg::IF_ID_W-1:0]     i_if_id,
    input wire [dbg_pkg::ID_EX_W-1:0]     i_id_ex,
    input wire [dbg_pkg::EX_MEM_W-1:0]    i_ex_mem,
    input wire [dbg_pkg::MEM_WB_W-1:0]    i_mem_wb
);

    localparam int DMEM_WORDS = 2 ** (dbg_pkg::DMEM_ADDR_W - 2);
    localparam int NZ_WORDS   = (DMEM_WORDS - 1) / 5 + 1; // every fifth word is nonzero
    localparam int MEM_FIRST  = dbg_pkg::NUM_REGS + dbg_pkg::NUM_LATCH_WORDS;
    localparam int LATCH_BITS = 32 * dbg_pkg::NUM_LATCH_WORDS;

    int errors       = 0;
    int tests_failed = 0;
    int test_errors  = 0;
    int word_cnt     = 0;
    int byte_cnt     = 0;
    int write_cnt    = 0;
    int pc_cnt       = 0;
    int halt_cnt     = 0;
    int stall_cnt    = 0;
    int n_instr      = 0;
    int exp_writes   = 0;
    int exp_pc       = 0;
    int exp_halt     = 0;
    int exp_stall    = 0;
    int exp_words    = 0;
    bit exp_full     = 1'b0;
    bit full_seen    = 1'b0;
    logic [31:0] shift = '0; // bytes of the word being rebuilt

    function automatic logic [31:0] program_word(input int i, input int n);
        if (i == n - 1)
            return dbg_pkg::END_INSTR;
        return 32'h2008_0000 + 32'(i); // addi-style filler
    endfunction

    function automatic logic [31:0] expected_word(input int k);
        logic [LATCH_BITS-1:0] latch_bits;
        int w;
        // latches laid end to end with if_id in the low bits and zeros on top
        latch_bits = LATCH_BITS'({i_mem_wb, i_ex_mem, i_id_ex, i_if_id});
        if (k < dbg_pkg::NUM_REGS)
            return 32'h0101_0101 * 32'(k);
        if (k < MEM_FIRST)
            return latch_bits[32*(k - dbg_pkg::NUM_REGS) +: 32];
        if (k < MEM_FIRST + 2 * NZ_WORDS) begin
            w = 5 * ((k - MEM_FIRST) / 2);
            return ((k - MEM_FIRST) % 2 == 0) ? 32'(w + 1) : 32'(4 * w); // data word then address
        end
        return dbg_pkg::END_DATA;
    endfunction

    task automatic value_error(input string sig, input logic [31:0] exp, input logic [31:0] act);
        $display("FAIL t=%0t signal=%s expected=%h actual=%h", $time, sig, exp, act);
        errors++;
        test_errors++;
    endtask

    task automatic count_error(input string what, input int exp, input int act);
        $display("FAIL t=%0t signal=%s expected=%0d actual=%0d", $time, what, exp, act);
        errors++;
        test_errors++;
    endtask

    task automatic start_test(input int n, input int writes, input int pcs, input int halts,
                              input int stalls, input int words, input bit full);
        n_instr     = n;
        exp_writes  = writes;
        exp_pc      = pcs;
        exp_halt    = halts;
        exp_stall   = stalls;
        exp_words   = words;
        exp_full    = full;
        test_errors = 0;
        word_cnt    = 0;
        byte_cnt    = 0;
        write_cnt   = 0;
        pc_cnt      = 0;
        halt_cnt    = 0;
        stall_cnt   = 0;
        full_seen   = 1'b0;
    endtask

    task automatic finish_test(input int id, input string name);
        if (write_cnt != exp_writes) count_error("o_imem_we strobes", exp_writes, write_cnt);
        if (pc_cnt != exp_pc) count_error("o_pc_reset pulses", exp_pc, pc_cnt);
        if (halt_cnt != exp_halt) count_error("o_halt low cycles", exp_halt, halt_cnt);
        if (stall_cnt != exp_stall) count_error("o_stall high cycles", exp_stall, stall_cnt);
        if (word_cnt != exp_words) count_error("o_tx_byte words", exp_words, word_cnt);
        if (byte_cnt != 0) count_error("o_tx_byte trailing bytes", 0, byte_cnt);
        if (exp_full && !full_seen) begin
            $display("transmit FIFO never filled while the UART was held busy");
            errors++;
            test_errors++;
        end
        if (test_errors != 0)
            tests_failed++;
        $display("test %0d %s: %s", id, name, (test_errors == 0) ? "ok" : "failed");
    endtask

    // registered outputs are settled by the falling edge
    always @(negedge i_clk) begin
        if (!i_reset) begin
            if (i_tx_start) begin
                shift = {shift[23:0], i_tx_byte}; // msb arrives first
                if (byte_cnt == 3) begin
                    if (word_cnt >= exp_words)
                        value_error("o_tx_byte extra word", 32'h0, shift);
                    else if (shift !== expected_word(word_cnt))
                        value_error($sformatf("o_tx_byte word %0d", word_cnt),
                                    expected_word(word_cnt), shift);
                    word_cnt++;
                    byte_cnt = 0;
                end else begin
                    byte_cnt++;
                end
            end
            if (i_imem_we) begin
                if (i_imem_addr !== 32'(4 * write_cnt))
                    value_error("o_imem_addr", 32'(4 * write_cnt), i_imem_addr);
                if (i_imem_data !== program_word(write_cnt, n_instr))
                    value_error("o_imem_data", program_word(write_cnt, n_instr), i_imem_data);
                write_cnt++;
            end
            if (i_pc_reset) pc_cnt++;
            if (!i_halt) halt_cnt++;
            if (i_stall) stall_cnt++;
            if (i_fifo_full) full_seen = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_debug_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_debug_subsystem;

    localparam int NUM_TESTS  = 8;
    localparam int TIMEOUT    = 20000; // long busy dump needs about 9500 cycles
    localparam int SETTLE     = 20;
    localparam int DMEM_WORDS = 2 ** (dbg_pkg::DMEM_ADDR_W - 2);
    localparam int NZ_WORDS   = (DMEM_WORDS - 1) / 5 + 1;
    localparam int DUMP_WORDS = dbg_pkg::NUM_REGS + dbg_pkg::NUM_LATCH_WORDS + 2 * NZ_WORDS + 1;

    typedef struct packed {
        logic [31:0] cmd;
        int          n_instr;   // words after the load command including END_INSTR
        int          end_after; // halt-low cycles until the end instr sits in decode
        int          busy_min;
        int          busy_max;
        int          exp_writes;
        int          exp_pc;
        int          exp_halt;
        int          exp_stall; // cycles the fetch stays parked during the drain
        int          exp_words;
        bit          exp_full;
    } test_t;

    logic                            i_clk = 1'b0;
    logic                            i_reset;
    logic                            i_rx_byte_valid;
    logic [7:0]                      i_rx_byte;
    logic                            i_tx_busy = 1'b0;
    logic                            o_tx_start;
    logic [7:0]                      o_tx_byte;
    logic                            o_halt;
    logic                            o_pc_reset;
    logic                            o_stall;
    logic                            o_imem_we;
    logic [31:0]                     o_imem_addr;
    logic [31:0]                     o_imem_data;
    logic [4:0]                      o_reg_addr;
    logic [dbg_pkg::DMEM_ADDR_W-1:0] o_dmem_addr;
    logic [dbg_pkg::DMEM_ADDR_W-3:0] dmem_word;
    logic [31:0]                     i_reg_data;
    logic [31:0]                     i_dmem_data;
    logic                            i_program_end = 1'b0;
    logic [dbg_pkg::IF_ID_W-1:0]     i_if_id;
    logic [dbg_pkg::ID_EX_W-1:0]     i_id_ex;
    logic [dbg_pkg::EX_MEM_W-1:0]    i_ex_mem;
    logic [dbg_pkg::MEM_WB_W-1:0]    i_mem_wb;
    logic [159:0]                    rnd;

    test_t  tests [NUM_TESTS];
    string  names [NUM_TESTS];
    test_t  cur;
    integer seed;
    int     end_after    = 1000;
    int     busy_min     = 1;
    int     busy_max     = 4;
    int     busy_left    = 0;
    int     halt_low_cnt = 0;
    bit     timed_out    = 1'b0;
    int     cycles;
    int     t;
    int     i;

    always #50 i_clk = ~i_clk;

    debug_subsystem i_debug_subsystem (.*);

    debug_checker i_debug_checker (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_tx_start(o_tx_start), .i_tx_byte(o_tx_byte),
        .i_imem_we(o_imem_we), .i_imem_addr(o_imem_addr), .i_imem_data(o_imem_data),
        .i_halt(o_halt), .i_pc_reset(o_pc_reset), .i_stall(o_stall),
        .i_fifo_full(i_debug_subsystem.fifo_full),
        .i_if_id(i_if_id), .i_id_ex(i_id_ex), .i_ex_mem(i_ex_mem), .i_mem_wb(i_mem_wb)
    );

    // register file and data memory answer in the same cycle
    assign i_reg_data  = 32'h0101_0101 * 32'(o_reg_addr);
    assign dmem_word   = o_dmem_addr[dbg_pkg::DMEM_ADDR_W-1:2];
    assign i_dmem_data = (32'(dmem_word) % 32'd5 == 32'd0) ? 32'(dmem_word) + 32'd1 : 32'd0;

    always @(negedge i_clk) begin
        if (i_reset || o_pc_reset)
            halt_low_cnt = 0;
        else if (!o_halt)
            halt_low_cnt = halt_low_cnt + 1; // pipeline advances only while released
        i_program_end = (halt_low_cnt >= end_after);
    end

    // uart transmitter stays busy for a while after every start
    always @(negedge i_clk) begin
        if (o_tx_start)
            busy_left = busy_min + int'({$random(seed)} % (busy_max - busy_min + 1));
        i_tx_busy = (busy_left > 0);
        if (busy_left > 0)
            busy_left = busy_left - 1;
    end

    function automatic logic [159:0] random_bits();
        return {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic send_word(input logic [31:0] w);
        int b;
        for (b = 3; b >= 0; b--) begin
            @(negedge i_clk);
            i_rx_byte_valid = 1'b1;
            i_rx_byte       = w[8*b +: 8]; // msb first
            @(negedge i_clk);
            i_rx_byte_valid = 1'b0;
        end
    endtask

    initial begin
        seed            = 32'hfc27ab94;
        i_reset         = 1'b1;
        i_rx_byte_valid = 1'b0;
        i_rx_byte       = 8'h00;
        rnd             = random_bits();
        i_if_id         = rnd[dbg_pkg::IF_ID_W-1:0];
        rnd             = random_bits();
        i_id_ex         = rnd[dbg_pkg::ID_EX_W-1:0];
        rnd             = random_bits();
        i_ex_mem        = rnd[dbg_pkg::EX_MEM_W-1:0];
        rnd             = random_bits();
        i_mem_wb        = rnd[dbg_pkg::MEM_WB_W-1:0];

        tests[0] = '{dbg_pkg::CMD_CONT, 0, 4, 1, 4, 0, 0, 0, 0, 0, 1'b0};
        tests[1] = '{dbg_pkg::CMD_LOAD, 6, 4, 1, 4, 6, 1, 0, 0, 0, 1'b0};
        tests[2] = '{dbg_pkg::CMD_CONT, 0, 6, 1, 4, 0, 1, 6 + dbg_pkg::DRAIN_CYCLES,
                     dbg_pkg::DRAIN_CYCLES, DUMP_WORDS, 1'b0};
        tests[3] = '{dbg_pkg::CMD_STEP, 0, 4, 1, 4, 0, 0, 0, 0, 0, 1'b0};
        tests[4] = '{dbg_pkg::CMD_NEXT, 0, 4, 1, 4, 0, 0, 1, 0, DUMP_WORDS, 1'b0};
        tests[5] = '{dbg_pkg::CMD_NEXT, 0, 4, 2, 3, 0, 0, 1, 0, DUMP_WORDS, 1'b0};
        tests[6] = '{dbg_pkg::CMD_CANCEL, 0, 4, 1, 4, 0, 1, 0, 0, 0, 1'b0};
        tests[7] = '{dbg_pkg::CMD_CONT, 0, 3, 30, 30, 0, 1, 3 + dbg_pkg::DRAIN_CYCLES,
                     dbg_pkg::DRAIN_CYCLES, DUMP_WORDS, 1'b1}; // slow uart so the fifo fills
        names = '{"cont before load", "load program", "continuous run", "enter step mode",
                  "first step", "second step", "cancel step", "long tx busy"};

        repeat (10) @(negedge i_clk);
        i_reset = 1'b0;

        for (t = 0; t < NUM_TESTS && !timed_out; t++) begin
            cur       = tests[t];
            end_after = cur.end_after;
            busy_min  = cur.busy_min;
            busy_max  = cur.busy_max;
            @(posedge i_clk);
            i_debug_checker.start_test(cur.n_instr, cur.exp_writes, cur.exp_pc, cur.exp_halt,
                                       cur.exp_stall, cur.exp_words, cur.exp_full);
            send_word(cur.cmd);
            for (i = 0; i < cur.n_instr; i++)
                send_word(i_debug_checker.program_word(i, cur.n_instr));
            cycles = 0;
            while ((i_debug_checker.word_cnt < cur.exp_words ||
                    i_debug_checker.pc_cnt < cur.exp_pc ||
                    i_debug_checker.write_cnt < cur.exp_writes) && cycles < TIMEOUT) begin
                @(posedge i_clk);
                cycles++;
            end
            if (cycles >= TIMEOUT) begin
                $display("timeout in test %0d (%s), the dump or strobes never completed",
                         t, names[t]);
                timed_out = 1'b1;
            end else begin
                repeat (SETTLE) @(posedge i_clk); // quiet window catches stray activity
                i_debug_checker.finish_test(t, names[t]);
            end
        end

        $display("%0d tests, %0d failed, %0d errors", NUM_TESTS,
                 i_debug_checker.tests_failed, i_debug_checker.errors);
        if (i_debug_checker.errors == 0 && !timed_out)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
src/dbg_pkg.sv
src/rx_word_assembler.sv
src/debug_unit.sv
src/tx_fifo.sv
src/tx_byte_sender.sv
src/debug_subsystem.sv
testbench/debug_checker.sv
testbench/tb_debug_subsystem.sv
